// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pipeCore_tb
FILELIST  ?= pipeCore.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
RUN_FLAGS ?= +verilator+error+limit+100
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: no verdict in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== pipeCore.f ====
+incdir+verilog
verilog/cpuPkg.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/hazardForward.sv
verilog/pipeCore.sv
tests/pipeCore_assert.sv
tests/pipeCore_tb.sv

// ==== tests/pipeCore_assert.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module pipeCore_assert (
    input wire                  Clk,
    input wire                  rstN,
    input wire                  dataReadEn,
    input wire                  dataWriteEn,
    input wire                  halted,
    input wire [`WORD_SIZE-1:0] numInst
);

    // One data access per cycle
    dataPortExclusive: assert property (@(posedge Clk) disable iff (!rstN)
        !(dataReadEn && dataWriteEn))
        else $error("dataReadEn and dataWriteEn high together");

    haltSticky: assert property (@(posedge Clk) disable iff (!rstN)
        halted |=> halted)
        else $error("halted dropped without a reset");

    countFrozen: assert property (@(posedge Clk) disable iff (!rstN)
        halted |=> $stable(numInst))
        else $error("numInst changed while halted");

endmodule

bind pipeCore pipeCore_assert assert_i (
    .Clk(Clk),
    .rstN(rstN),
    .dataReadEn(dataReadEn),
    .dataWriteEn(dataWriteEn),
    .halted(halted),
    .numInst(numInst)
);

`default_nettype wire

// ==== tests/pipeCore_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module pipeCore_tb;

    localparam int NUM_TESTS     = 5;
    localparam int TRACE_DEPTH   = 128;
    localparam int HALT_TIMEOUT  = 400;
    localparam int SETTLE_CYCLES = 8;

    logic                  Clk;
    logic                  rstN;
    logic [`WORD_SIZE-1:0] instAddr;
    logic                  instReadEn;
    logic [`WORD_SIZE-1:0] instData;
    logic [`WORD_SIZE-1:0] dataAddr;
    logic                  dataReadEn;
    logic                  dataWriteEn;
    logic [`WORD_SIZE-1:0] dataWrData;
    logic [`WORD_SIZE-1:0] dataRdData;
    logic [`WORD_SIZE-1:0] outputPort;
    logic [`WORD_SIZE-1:0] numInst;
    logic                  halted;

    // 256 words each, addresses wrap
    logic [`WORD_SIZE-1:0] instMem [256];
    logic [`WORD_SIZE-1:0] dataMem [256];
    logic [31:0]           trace [TRACE_DEPTH];

    logic [`WORD_SIZE-1:0] expOut [$];
    int                    expTest [$];
    logic [7:0]            finalAddr [$];
    logic [`WORD_SIZE-1:0] finalData [$];
    logic [`WORD_SIZE-1:0] expCount;
    int                    testErrors [$];
    int                    outIdx;
    logic [`WORD_SIZE-1:0] lastOut;
    logic                  haltSeen;

    pipeCore dut_i (
        .Clk(Clk),
        .rstN(rstN),
        .instAddr(instAddr),
        .instReadEn(instReadEn),
        .instData(instData),
        .dataAddr(dataAddr),
        .dataReadEn(dataReadEn),
        .dataWriteEn(dataWriteEn),
        .dataWrData(dataWrData),
        .dataRdData(dataRdData),
        .outputPort(outputPort),
        .numInst(numInst),
        .halted(halted)
    );

    // Combinational reads, writes on the rising edge
    assign instData   = instReadEn ? instMem[instAddr[7:0]] : '0;
    assign dataRdData = dataReadEn ? dataMem[dataAddr[7:0]] : '0;

    always #10 Clk = ~Clk;

    always @(posedge Clk) begin
        if (dataWriteEn) begin
            dataMem[dataAddr[7:0]] <= dataWrData;
        end
    end

    function automatic string testName(input int t);
        case (t)
            1:       return "arithmetic and forwarding";
            2:       return "load, store and load-use";
            3:       return "branches";
            4:       return "JMP and LHI";
            default: return "HLT and retired count";
        endcase
    endfunction

    task automatic countError(input int test);
        if (test >= 1 && test <= NUM_TESTS) begin
            testErrors[test] = testErrors[test] + 1;
        end else begin
            testErrors[NUM_TESTS] = testErrors[NUM_TESTS] + 1;
        end
    endtask

    task automatic loadTrace();
        logic [3:0]            kind;
        logic [11:0]           field;
        logic [`WORD_SIZE-1:0] value;
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            trace[i] = '0;
        end
        $readmemh("tests/pipeCore_trace.txt", trace);
        for (int i = 0; i < TRACE_DEPTH; i++) begin
            kind  = trace[i][31:28];
            field = trace[i][27:16];
            value = trace[i][15:0];
            case (kind)
                4'h1: instMem[field[7:0]] = value;
                4'h2: dataMem[field[7:0]] = value;
                4'h3: begin
                    expOut.push_back(value);
                    expTest.push_back(int'(field));
                end
                4'h4: expCount = value;
                4'h5: begin
                    finalAddr.push_back(field[7:0]);
                    finalData.push_back(value);
                end
                default: ;
            endcase
        end
    endtask

    task automatic checkOutput(input logic [`WORD_SIZE-1:0] value);
        if (outIdx >= expOut.size()) begin
            $display("Error: outputPort unexpected value 0x%h after the last expected one", value);
            countError(NUM_TESTS);
        end else begin
            if (value !== expOut[outIdx]) begin
                $display("Error: outputPort expected 0x%h got 0x%h", expOut[outIdx], value);
                countError(expTest[outIdx]);
            end
            outIdx++;
        end
    endtask

    // Outputs settle at the rising edge, sample on the falling one
    always @(negedge Clk) begin
        if (rstN) begin
            if (outputPort !== lastOut) begin
                checkOutput(outputPort);
                lastOut = outputPort;
            end
            if (dataReadEn && dataWriteEn) begin
                $display("Data memory was read and written in the same cycle");
                countError(2);
            end
            if (haltSeen && halted !== 1'b1) begin
                $display("halted dropped while the core was halted");
                countError(5);
            end
            if (halted === 1'b1) begin
                haltSeen = 1'b1;
            end
        end
    end

    task automatic runEndChecks(input logic [`WORD_SIZE-1:0] countAtHalt,
                                input logic [`WORD_SIZE-1:0] outAtHalt);
        for (int k = outIdx; k < expOut.size(); k++) begin
            $display("Expected output value 0x%h never appeared", expOut[k]);
            countError(expTest[k]);
        end
        for (int k = 0; k < finalAddr.size(); k++) begin
            if (dataMem[finalAddr[k]] !== finalData[k]) begin
                $display("Error: dataMem[0x%h] expected 0x%h got 0x%h",
                         finalAddr[k], finalData[k], dataMem[finalAddr[k]]);
                countError(2);
            end
        end
        if (countAtHalt !== expCount) begin
            $display("Error: numInst expected 0x%h got 0x%h", expCount, countAtHalt);
            countError(5);
        end
        if (numInst !== countAtHalt) begin
            $display("Error: numInst after halt expected 0x%h got 0x%h", countAtHalt, numInst);
            countError(5);
        end
        if (outputPort !== outAtHalt) begin
            $display("Error: outputPort after halt expected 0x%h got 0x%h",
                     outAtHalt, outputPort);
            countError(5);
        end
        // Fetch is off once HLT has been decoded
        if (instReadEn !== 1'b0) begin
            $display("Error: instReadEn after halt expected 0x0 got 0x%h", instReadEn);
            countError(5);
        end
    endtask

    task automatic reportTests(output int failed);
        failed = 0;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            if (testErrors[t] == 0) begin
                $display("Test %0d %s: ok", t, testName(t));
            end else begin
                $display("Test %0d %s: FAILED with %0d errors", t, testName(t), testErrors[t]);
                failed++;
            end
        end
        $display("Tests passed: %0d, tests with errors: %0d", NUM_TESTS - failed, failed);
    endtask

    initial begin
        int                    waitCycles;
        int                    failedTests;
        logic [`WORD_SIZE-1:0] countAtHalt;
        logic [`WORD_SIZE-1:0] outAtHalt;

        Clk      = 1'b0;
        rstN     = 1'b0;
        outIdx   = 0;
        lastOut  = '0;
        haltSeen = 1'b0;
        expCount = '0;
        for (int t = 0; t <= NUM_TESTS; t++) begin
            testErrors.push_back(0);
        end
        for (int a = 0; a < 256; a++) begin
            instMem[a] = '0;
            dataMem[a] = '0;
        end
        loadTrace();
        if (expOut.size() == 0) begin
            $display("The trace file gave no expected output values");
            countError(1);
        end

        repeat (5) @(posedge Clk);
        rstN <= 1'b1;

        waitCycles = 0;
        while (halted !== 1'b1 && waitCycles < HALT_TIMEOUT) begin
            @(negedge Clk);
            waitCycles++;
        end

        if (halted !== 1'b1) begin
            $display("Timeout: halted did not rise within %0d cycles", HALT_TIMEOUT);
            $display("Regression failed");
            $finish;
        end else begin
            countAtHalt = numInst;
            outAtHalt   = outputPort;
            // Watch a few cycles past the halt
            repeat (SETTLE_CYCLES) @(negedge Clk);
            runEndChecks(countAtHalt, outAtHalt);
            reportTests(failedTests);
            if (failedTests == 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tests/pipeCore_trace.txt ====
// One word per entry, kind in bits 31:28, field in 27:16, value in 15:0
// Kind 1 program word, 2 initial data, 3 output (field is test), 4 retired count, 5 final data
// Test 1, dependent ALU chain with forwarding
1000410C 1001460A 1002F6C0 1003FC1C 1004FDC1 1005FC1C
1006F6C2 1007FC1C 1008F6C3 1009FC1C
30010022 30010016 30010004 3001001E
// Test 2, store, reload and load-use
100A8330 100B7230 100CF9C0 100DFC1C 100E8331 100F7132 1010F41C
20301234 20315A5A 20320077
3002002A 30020077
5030001E 5031002A
// Test 3, taken BEQ then not-taken BNE
10111502 1012F81C 1013FC1C 10144255 1015F81C
10160503 10174366 1018FC1C
30030055 30030066
// Test 4, JMP over a WWD, LHI and ORI
1019901B 101AF41C 101B62A5 101C5A3C 101DF81C
3004A53C
// Test 5, HLT and the retired count
101EF01D 101FFC1C
4000001C

// ==== verilog/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module aluUnit (
    input  wire [`WORD_SIZE-1:0]  a,
    input  wire [`WORD_SIZE-1:0]  b,
    input  wire cpuPkg::aluOpE    op,
    input  wire                   isBranch,
    input  wire cpuPkg::opcodeE   opcode,
    output logic [`WORD_SIZE-1:0] result,
    output logic                  branchTaken
);

    logic equal;

    always_comb begin
        case (op)
            cpuPkg::ALU_ADD: result = a + b;
            cpuPkg::ALU_SUB: result = a - b;
            cpuPkg::ALU_AND: result = a & b;
            cpuPkg::ALU_OR:  result = a | b;
            default:         result = a;
        endcase
    end

    assign equal = (a == b);

    always_comb begin
        branchTaken = 1'b0;
        if (isBranch) begin
            case (opcode)
                cpuPkg::BEQ: branchTaken = equal;
                cpuPkg::BNE: branchTaken = !equal;
                default:     branchTaken = 1'b0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module controlDecoder (
    input  wire [`WORD_SIZE-1:0]  instr,
    output cpuPkg::ctrlT          ctrl,
    output logic [`REG_IDX_W-1:0] rs,
    output logic [`REG_IDX_W-1:0] rt,
    output logic [`REG_IDX_W-1:0] rd,
    output logic [`WORD_SIZE-1:0] imm,
    output logic                  usesRs,
    output logic                  usesRt
);

    cpuPkg::opcodeE opcode;
    cpuPkg::funcE   func;

    assign opcode = cpuPkg::opcodeE'(instr[15:12]);
    assign func   = cpuPkg::funcE'(instr[5:0]);
    assign rs     = instr[11:10];
    assign rt     = instr[9:8];

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = cpuPkg::ALU_ADD;
        rd         = instr[9:8];
        imm        = {{(`WORD_SIZE-8){instr[7]}}, instr[7:0]};
        usesRs     = 1'b1;
        usesRt     = 1'b0;
        case (opcode)
            cpuPkg::ADI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::ORI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = cpuPkg::ALU_OR;
            end
            cpuPkg::LHI: begin
                // Immediate goes to the upper byte, added to zero
                imm            = {instr[7:0], {(`WORD_SIZE-8){1'b0}}};
                usesRs         = 1'b0;
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::LWD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::SWD: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                usesRt         = 1'b1;
            end
            cpuPkg::BNE, cpuPkg::BEQ: begin
                ctrl.isBranch = 1'b1;
                ctrl.aluOp    = cpuPkg::ALU_SUB;
                usesRt        = 1'b1;
            end
            cpuPkg::JMP: begin
                ctrl.isJump = 1'b1;
                usesRs      = 1'b0;
            end
            cpuPkg::RTYPE: begin
                rd = instr[7:6];
                case (func)
                    cpuPkg::ADD: begin
                        ctrl.regWrite = 1'b1;
                        usesRt        = 1'b1;
                    end
                    cpuPkg::SUB: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = cpuPkg::ALU_SUB;
                        usesRt        = 1'b1;
                    end
                    cpuPkg::AND: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = cpuPkg::ALU_AND;
                        usesRt        = 1'b1;
                    end
                    cpuPkg::ORR: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = cpuPkg::ALU_OR;
                        usesRt        = 1'b1;
                    end
                    cpuPkg::WWD: begin
                        ctrl.isWwd = 1'b1;
                        ctrl.aluOp = cpuPkg::ALU_PASSA;
                    end
                    cpuPkg::HLT: begin
                        ctrl.isHalt = 1'b1;
                        usesRs      = 1'b0;
                    end
                    default: usesRs = 1'b0;
                endcase
            end
            default: usesRs = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    // Opcode field, instr[15:12]
    typedef enum logic [3:0] {
        BNE   = 4'd0,
        BEQ   = 4'd1,
        ADI   = 4'd4,
        ORI   = 4'd5,
        LHI   = 4'd6,
        LWD   = 4'd7,
        SWD   = 4'd8,
        JMP   = 4'd9,
        RTYPE = 4'd15
    } opcodeE;

    // Function field under RTYPE, instr[5:0]
    typedef enum logic [5:0] {
        ADD = 6'd0,
        SUB = 6'd1,
        AND = 6'd2,
        ORR = 6'd3,
        WWD = 6'd28,
        HLT = 6'd29
    } funcE;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASSA
    } aluOpE;

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;
        logic  isBranch;
        logic  isJump;
        logic  isWwd;
        logic  isHalt;
        aluOpE aluOp;
    } ctrlT;

endpackage

`default_nettype wire

// ==== verilog/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and address width
`define WORD_SIZE 16

// Register file geometry
`define REG_COUNT 4
`define REG_IDX_W 2

`endif

// ==== verilog/hazardForward.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module hazardForward (
    input  wire [`REG_IDX_W-1:0] exRs,
    input  wire [`REG_IDX_W-1:0] exRt,
    input  wire [`REG_IDX_W-1:0] memRd,
    input  wire                  memRegWrite,
    wbBus.sink                   wb,
    input  wire [`REG_IDX_W-1:0] idRs,
    input  wire [`REG_IDX_W-1:0] idRt,
    input  wire                  idUsesRs,
    input  wire                  idUsesRt,
    input  wire                  exMemRead,
    input  wire [`REG_IDX_W-1:0] exRd,
    output logic [1:0]           fwdA,
    output logic [1:0]           fwdB,
    output logic                 stall
);

    logic wbWrites;

    // 01 takes the memory stage, 10 takes writeback, memory wins
    function automatic logic [1:0] pickSource(input logic [`REG_IDX_W-1:0] src);
        logic [1:0] sel;
        sel = 2'b00;
        if (memRegWrite && memRd == src) begin
            sel = 2'b01;
        end else if (wbWrites && wb.rd == src) begin
            sel = 2'b10;
        end
        return sel;
    endfunction

    assign wbWrites = wb.valid && wb.regWrite;

    always_comb begin
        fwdA = pickSource(exRs);
        fwdB = pickSource(exRt);
    end

    // Load in execute feeding the instruction in decode
    assign stall = exMemRead &&
                   ((idUsesRs && idRs == exRd) || (idUsesRt && idRt == exRd));

endmodule

`default_nettype wire

// ==== verilog/pipeCore.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

interface wbBus;
    logic                  valid;
    logic                  regWrite;
    logic [`REG_IDX_W-1:0] rd;
    logic [`WORD_SIZE-1:0] data;

    modport source (output valid, regWrite, rd, data);
    modport sink   (input valid, regWrite, rd, data);
endinterface

module pipeCore (
    input  wire                   Clk,
    input  wire                   rstN,
    output logic [`WORD_SIZE-1:0] instAddr,
    output logic                  instReadEn,
    input  wire [`WORD_SIZE-1:0]  instData,
    output logic [`WORD_SIZE-1:0] dataAddr,
    output logic                  dataReadEn,
    output logic                  dataWriteEn,
    output logic [`WORD_SIZE-1:0] dataWrData,
    input  wire [`WORD_SIZE-1:0]  dataRdData,
    output logic [`WORD_SIZE-1:0] outputPort,
    output logic [`WORD_SIZE-1:0] numInst,
    output logic                  halted
);

    logic [`WORD_SIZE-1:0] pc, pcNext, jumpTarget, branchTarget;
    logic                  fetchStopped;

    logic                  ifIdBubble;
    logic [`WORD_SIZE-1:0] ifIdInstr, ifIdPc;

    cpuPkg::ctrlT          idCtrl;
    logic [`REG_IDX_W-1:0] idRs, idRt, idRd;
    logic [`WORD_SIZE-1:0] idImm, idRsData, idRtData;
    logic                  decUsesRs, decUsesRt, idValid, idKill;
    logic                  jumpTaken, haltDecoded, stall;

    logic                  idExBubble, idExUsesRs;
    cpuPkg::ctrlT          idExCtrl;
    cpuPkg::opcodeE        idExOpcode;
    logic [`WORD_SIZE-1:0] idExPc, idExRsData, idExRtData, idExImm;
    logic [`REG_IDX_W-1:0] idExRs, idExRt, idExRd;

    logic [1:0]            fwdA, fwdB;
    logic [`WORD_SIZE-1:0] exFwdA, exFwdB, aluA, aluB, aluResult;
    logic                  branchTaken;

    logic                  exMemBubble;
    cpuPkg::ctrlT          exMemCtrl;
    logic [`WORD_SIZE-1:0] exMemResult, exMemRtData, memFwdData;
    logic [`REG_IDX_W-1:0] exMemRd;

    logic                  memWbBubble;
    cpuPkg::ctrlT          memWbCtrl;
    logic [`WORD_SIZE-1:0] memWbResult, memWbLoadData;
    logic [`REG_IDX_W-1:0] memWbRd;

    wbBus wbIf ();

    controlDecoder decoder_i (
        .instr(ifIdInstr), .ctrl(idCtrl), .rs(idRs), .rt(idRt), .rd(idRd),
        .imm(idImm), .usesRs(decUsesRs), .usesRt(decUsesRt)
    );

    regFile regFile_i (
        .Clk(Clk), .rstN(rstN), .rs(idRs), .rt(idRt),
        .rsData(idRsData), .rtData(idRtData), .wb(wbIf)
    );

    hazardForward hazard_i (
        .exRs(idExRs), .exRt(idExRt), .memRd(exMemRd), .memRegWrite(exMemCtrl.regWrite),
        .wb(wbIf), .idRs(idRs), .idRt(idRt),
        .idUsesRs(decUsesRs && idValid), .idUsesRt(decUsesRt && idValid),
        .exMemRead(idExCtrl.memRead), .exRd(idExRd),
        .fwdA(fwdA), .fwdB(fwdB), .stall(stall)
    );

    aluUnit alu_i (
        .a(aluA), .b(aluB), .op(idExCtrl.aluOp), .isBranch(idExCtrl.isBranch),
        .opcode(idExOpcode), .result(aluResult), .branchTaken(branchTaken)
    );

    // Decode side redirects, a taken branch in execute overrides both
    assign idValid     = !ifIdBubble;
    assign jumpTaken   = idValid && idCtrl.isJump && !branchTaken;
    assign haltDecoded = idValid && idCtrl.isHalt && !branchTaken;
    assign idKill      = !idValid || stall || branchTaken;

    assign jumpTarget   = {ifIdPc[`WORD_SIZE-1:12], ifIdInstr[11:0]};
    assign branchTarget = idExPc + `WORD_SIZE'd1 + idExImm;
    assign pcNext       = branchTaken ? branchTarget :
                          jumpTaken   ? jumpTarget   : pc + `WORD_SIZE'd1;

    assign memFwdData = exMemCtrl.memToReg ? dataRdData : exMemResult;

    always_comb begin
        case (fwdA)
            2'b01:   exFwdA = memFwdData;
            2'b10:   exFwdA = wbIf.data;
            default: exFwdA = idExRsData;
        endcase
        case (fwdB)
            2'b01:   exFwdB = memFwdData;
            2'b10:   exFwdB = wbIf.data;
            default: exFwdB = idExRtData;
        endcase
    end

    // LHI reads no rs and adds its immediate to zero
    assign aluA = idExUsesRs ? exFwdA : '0;
    assign aluB = idExCtrl.aluSrcImm ? idExImm : exFwdB;

    assign instAddr    = pc;
    assign instReadEn  = !fetchStopped;
    assign dataAddr    = exMemResult;
    assign dataReadEn  = exMemCtrl.memRead;
    assign dataWriteEn = exMemCtrl.memWrite;
    assign dataWrData  = exMemRtData;

    assign wbIf.valid    = !memWbBubble;
    assign wbIf.regWrite = memWbCtrl.regWrite;
    assign wbIf.rd       = memWbRd;
    assign wbIf.data     = memWbCtrl.memToReg ? memWbLoadData : memWbResult;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            pc           <= '0;
            fetchStopped <= 1'b0;
            ifIdBubble   <= 1'b1;
            idExBubble   <= 1'b1;
            idExCtrl     <= '0;
            exMemBubble  <= 1'b1;
            exMemCtrl    <= '0;
            memWbBubble  <= 1'b1;
            memWbCtrl    <= '0;
            numInst      <= '0;
            outputPort   <= '0;
            halted       <= 1'b0;
        end else begin
            if (branchTaken || (!stall && !haltDecoded && !fetchStopped)) begin
                pc <= pcNext;
            end
            if (haltDecoded) begin
                fetchStopped <= 1'b1;
            end

            if (branchTaken) begin
                ifIdBubble <= 1'b1;
            end else if (!stall) begin
                ifIdBubble <= jumpTaken || haltDecoded || fetchStopped;
            end

            idExBubble  <= idKill;
            idExCtrl    <= idKill ? '0 : idCtrl;
            exMemBubble <= idExBubble;
            exMemCtrl   <= idExCtrl;
            memWbBubble <= exMemBubble;
            memWbCtrl   <= exMemCtrl;

            // Retire at the end of the writeback cycle
            if (!memWbBubble) begin
                numInst <= numInst + `WORD_SIZE'd1;
                if (memWbCtrl.isWwd) begin
                    outputPort <= memWbResult;
                end
                if (memWbCtrl.isHalt) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall) begin
            ifIdInstr <= instData;
            ifIdPc    <= pc;
        end
        idExPc        <= ifIdPc;
        idExRsData    <= idRsData;
        idExRtData    <= idRtData;
        idExRs        <= idRs;
        idExRt        <= idRt;
        idExRd        <= idRd;
        idExImm       <= idImm;
        idExOpcode    <= cpuPkg::opcodeE'(ifIdInstr[15:12]);
        idExUsesRs    <= decUsesRs;
        exMemResult   <= aluResult;
        exMemRtData   <= exFwdB;
        exMemRd       <= idExRd;
        memWbResult   <= exMemResult;
        memWbLoadData <= dataRdData;
        memWbRd       <= exMemRd;
    end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module regFile (
    input  wire                   Clk,
    input  wire                   rstN,
    input  wire [`REG_IDX_W-1:0]  rs,
    input  wire [`REG_IDX_W-1:0]  rt,
    output logic [`WORD_SIZE-1:0] rsData,
    output logic [`WORD_SIZE-1:0] rtData,
    wbBus.sink                    wb
);

    logic [`WORD_SIZE-1:0] regs [`REG_COUNT];
    logic                  wrEn;

    assign wrEn = wb.valid && wb.regWrite;

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Write-through, decode sees the value retiring this cycle
    assign rsData = (wrEn && wb.rd == rs) ? wb.data : regs[rs];
    assign rtData = (wrEn && wb.rd == rt) ? wb.data : regs[rt];

endmodule

`default_nettype wire
